//--- bench/rx_model.svh
// Receive chain reference model

`ifndef RX_MODEL_SVH
`define RX_MODEL_SVH

// Register copies that follow the bus one edge after the write
logic        m_run;
logic [15:0] m_off_i;
logic [15:0] m_off_q;
logic        m_swap;
int          m_shift;
int          m_spp;
logic [31:0] m_time_hi;
logic [63:0] m_time;
logic [7:0]  m_led_sw;
logic [7:0]  m_led_src;

// Partial decimation group
int          acc_i;
int          acc_q;
int          acc_n;
logic        acc_ovf;

// Decimated samples and the radio time the framer sees each one at
logic [31:0] dec_iq[$];
logic        dec_ovf[$];
logic [63:0] dec_time[$];

function automatic void clear_group();
   acc_i   = 0;
   acc_q   = 0;
   acc_n   = 0;
   acc_ovf = 1'b0;
endfunction

// ADC word times four, minus the offset, clipped to 16 bits
function automatic logic [15:0] front_value(input logic [13:0] adc, input logic [15:0] offset);
   int v;
   v = 4 * int'($signed(adc)) - int'($signed(offset));
   if (v > 32767)
      v = 32767;
   else if (v < -32768)
      v = -32768;
   return v[15:0];
endfunction

// Effect of one clock edge, given the write that was on the bus before it
function automatic void model_edge(input logic stb, input logic [7:0] addr,
                                   input logic [31:0] data);
   if (stb && addr == settings_pkg::SR_TIME_LO)
      m_time = {m_time_hi, data};
   else
      m_time = m_time + 64'd1;
   if (stb) begin
      case (addr)
         settings_pkg::SR_RUN: begin
            if (data[0] && !m_run)
               clear_group();
            m_run = data[0];
         end
         settings_pkg::SR_LED_SW:      m_led_sw  = data[7:0];
         settings_pkg::SR_LED_SRC:     m_led_src = data[7:0];
         settings_pkg::SR_TIME_HI:     m_time_hi = data;
         settings_pkg::SR_DC_OFFSET_I: m_off_i   = data[15:0];
         settings_pkg::SR_DC_OFFSET_Q: m_off_q   = data[15:0];
         settings_pkg::SR_IQ_SWAP:     m_swap    = data[0];
         settings_pkg::SR_SPP:         m_spp     = data;
         settings_pkg::SR_DECIM_SHIFT: m_shift   = data;
         default: ;
      endcase
   end
endfunction

// One ADC pair taken by the front end while run is set
function automatic void model_sample(input logic [13:0] a, input logic [13:0] b,
                                     input logic ovf);
   logic [15:0] si;
   logic [15:0] sq;
   int          di;
   int          dq;
   si      = front_value(m_swap ? b : a, m_off_i);
   sq      = front_value(m_swap ? a : b, m_off_q);
   acc_i   = acc_i + int'($signed(si));
   acc_q   = acc_q + int'($signed(sq));
   acc_ovf = acc_ovf | ovf;
   acc_n   = acc_n + 1;
   if (acc_n == (1 << m_shift)) begin
      di = acc_i >>> m_shift;
      dq = acc_q >>> m_shift;
      dec_iq.push_back({di[15:0], dq[15:0]});
      dec_ovf.push_back(acc_ovf);
      // Front end and decimator each add one edge
      dec_time.push_back(m_time + 64'd2);
      clear_group();
   end
endfunction

// Each LED bit picks hardware or software by its source bit
function automatic logic [7:0] led_expect(input logic [7:0] src, input logic [7:0] sw,
                                          input logic run, input logic ovr);
   logic [7:0] hw;
   logic [7:0] led;
   int         b;
   hw    = 8'h00;
   hw[3] = run;
   hw[2] = ovr;
   for (b = 0; b < 8; b++)
      led[b] = src[b] ? hw[b] : sw[b];
   return led;
endfunction

`endif

//--- bench/tb_rx_core.sv
// Receive channel testbench

module tb_rx_core;

   localparam int CLK_PERIOD     = 10;
   localparam int RESET_CYCLES   = 5;
   // Longest session is four packets of 8 samples at shift 4, plus setup and drain
   localparam int SESSION_CYCLES = 4 * 8 * 16 + 300;
   localparam int LED_CYCLES     = 100;
   localparam int TOTAL_CYCLES   = RESET_CYCLES + 4 * SESSION_CYCLES + LED_CYCLES;

   logic        dsp_clk;
   logic        reset_i;
   logic        set_stb_i;
   logic [7:0]  set_addr_i;
   logic [31:0] set_data_i;
   logic [13:0] adc_a_i;
   logic [13:0] adc_b_i;
   logic        adc_ovf_a_i;
   logic        adc_ovf_b_i;
   logic [35:0] rx_data_o;
   logic        rx_valid_o;
   logic        rx_ready_i;
   logic        overrun_o;
   logic [7:0]  leds_o;

   // Bus write of the current cycle that the model applies after the edge
   logic        pend_stb;
   logic [7:0]  pend_addr;
   logic [31:0] pend_data;
   int          ready_mode;
   logic [35:0] out_words[$];
   string       cur_test;
   int          test_errs;
   int          tests_run;
   int          tests_failed;
   int          total_errs;

`include "rx_model.svh"

   rx_core i_dut (
      .dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .adc_ovf_a_i (adc_ovf_a_i),
      .adc_ovf_b_i (adc_ovf_b_i),
      .rx_data_o   (rx_data_o),
      .rx_valid_o  (rx_valid_o),
      .rx_ready_i  (rx_ready_i),
      .overrun_o   (overrun_o),
      .leds_o      (leds_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   // Word transfers at the next rising edge
   always @(negedge dsp_clk) begin
      if (!reset_i && rx_valid_o && rx_ready_i)
         out_words.push_back(rx_data_o);
   end

   initial begin
      #((TOTAL_CYCLES * 4 + 1000) * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("Test failures found");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // Reporting

   task automatic report_mismatch(input string what, input logic [63:0] exp,
                                  input logic [63:0] act);
      $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
      test_errs++;
   endtask

   task automatic report_error(input string msg);
      $display("Error in %s: %s", cur_test, msg);
      test_errs++;
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      total_errs += test_errs;
      if (test_errs == 0) begin
         $display("Test %s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("Test %s: %0d errors", cur_test, test_errs);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus

   // One clock cycle with inputs changing 1 unit after the rising edge
   task automatic step(input logic stb, input logic [7:0] addr, input logic [31:0] data);
      logic [13:0] a;
      logic [13:0] b;
      logic        oa;
      logic        ob;
      @(posedge dsp_clk);
      #1;
      if (!reset_i)
         model_edge(pend_stb, pend_addr, pend_data);
      a           = 14'($urandom);
      b           = 14'($urandom);
      oa          = ($urandom_range(0, 15) == 0);
      ob          = ($urandom_range(0, 15) == 0);
      adc_a_i     = a;
      adc_b_i     = b;
      adc_ovf_a_i = oa;
      adc_ovf_b_i = ob;
      if (m_run)
         model_sample(a, b, oa | ob);
      set_stb_i  = stb;
      set_addr_i = addr;
      set_data_i = data;
      pend_stb   = stb;
      pend_addr  = addr;
      pend_data  = data;
      case (ready_mode)
         0:       rx_ready_i = 1'b0;
         1:       rx_ready_i = 1'b1;
         default: rx_ready_i = ($urandom_range(0, 3) != 0);
      endcase
   endtask

   task automatic idle(input int n);
      repeat (n) step(1'b0, 8'h00, 32'h0);
   endtask

   task automatic write_reg(input settings_pkg::setting_addr_e addr, input logic [31:0] data);
      step(1'b1, addr, data);
   endtask

   // Random offsets and swap, fresh time load, then run
   task automatic start_stream(input int spp, input int shift);
      write_reg(settings_pkg::SR_DC_OFFSET_I, $urandom);
      write_reg(settings_pkg::SR_DC_OFFSET_Q, $urandom);
      write_reg(settings_pkg::SR_IQ_SWAP, $urandom_range(0, 1));
      write_reg(settings_pkg::SR_SPP, spp);
      write_reg(settings_pkg::SR_DECIM_SHIFT, shift);
      write_reg(settings_pkg::SR_TIME_HI, $urandom);
      write_reg(settings_pkg::SR_TIME_LO, $urandom);
      write_reg(settings_pkg::SR_RUN, 32'd1);
      dec_iq.delete();
      dec_ovf.delete();
      dec_time.delete();
      out_words.delete();
   endtask

   task automatic stop_stream();
      int n;
      write_reg(settings_pkg::SR_RUN, 32'd0);
      idle(4);
      n = 0;
      while (rx_valid_o && n < 200) begin
         idle(1);
         n++;
      end
      if (rx_valid_o)
         report_error("output stream did not drain after run was cleared");
   endtask

   //////////////////////////////////////////////////////////////////////
   // Packet checks

   // Complete packets are matched to the model by timestamp
   task automatic check_packets(input int min_count, input bit consecutive);
      logic [35:0] pkt[$];
      logic [35:0] exp_w;
      logic [63:0] ts;
      logic [63:0] prev_ts;
      int          count;
      int          base;
      int          k;
      count   = 0;
      prev_ts = '0;
      foreach (out_words[n]) begin
         if (out_words[n][stream_pkg::FLAG_SOF])
            pkt.delete();
         pkt.push_back(out_words[n]);
         if (out_words[n][stream_pkg::FLAG_EOF]) begin
            if (!pkt[0][stream_pkg::FLAG_SOF] || pkt.size() != m_spp + 2) begin
               report_error($sformatf("EOF closed a packet of %0d words", pkt.size()));
            end else begin
               ts = {pkt[0][31:0], pkt[1][31:0]};
               if (pkt[0][35:32] != 4'b0001)
                  report_mismatch("header word 0 flags", 4'b0001, pkt[0][35:32]);
               if (pkt[1][35:32] != 4'b0000)
                  report_mismatch("header word 1 flags", 4'b0000, pkt[1][35:32]);
               if (consecutive && count > 0 && ts != prev_ts + 64'(m_spp << m_shift))
                  report_mismatch("timestamp step", prev_ts + 64'(m_spp << m_shift), ts);
               base = -1;
               for (k = 0; k < dec_time.size(); k += m_spp) begin
                  if (base < 0 && dec_time[k] == ts)
                     base = k;
               end
               if (base < 0 || base + m_spp > dec_iq.size()) begin
                  report_error($sformatf("no model packet has timestamp %h", ts));
               end else begin
                  for (k = 0; k < m_spp; k++) begin
                     exp_w = {1'b0, dec_ovf[base + k], k == m_spp - 1, 1'b0, dec_iq[base + k]};
                     if (pkt[k + 2] !== exp_w)
                        report_mismatch($sformatf("sample word %0d", k), exp_w, pkt[k + 2]);
                  end
               end
               prev_ts = ts;
               count++;
            end
            pkt.delete();
         end
      end
      if (count < min_count)
         report_error($sformatf("only %0d complete packets, at least %0d expected",
                                count, min_count));
      out_words.delete();
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      logic [7:0] exp_led;
      int         n;
      void'($urandom(49));
      reset_i      = 1'b1;
      set_stb_i    = 1'b0;
      set_addr_i   = '0;
      set_data_i   = '0;
      adc_a_i      = '0;
      adc_b_i      = '0;
      adc_ovf_a_i  = 1'b0;
      adc_ovf_b_i  = 1'b0;
      rx_ready_i   = 1'b0;
      pend_stb     = 1'b0;
      pend_addr    = '0;
      pend_data    = '0;
      ready_mode   = 2;
      tests_run    = 0;
      tests_failed = 0;
      total_errs   = 0;
      m_run        = 1'b0;
      m_off_i      = '0;
      m_off_q      = '0;
      m_swap       = 1'b0;
      m_shift      = settings_pkg::RX_CONFIG_RESET.decim_shift;
      m_spp        = settings_pkg::RX_CONFIG_RESET.spp;
      m_time_hi    = '0;
      m_time       = '0;
      m_led_sw     = 8'h00;
      m_led_src    = settings_pkg::LED_SRC_RESET;
      clear_group();

      repeat (RESET_CYCLES) step(1'b0, 8'h00, 32'h0);
      reset_i = 1'b0;

      start_test("reset_defaults");
      idle(1);
      if (rx_valid_o !== 1'b0)
         report_mismatch("rx_valid_o", 1'b0, rx_valid_o);
      if (overrun_o !== 1'b0)
         report_mismatch("overrun_o", 1'b0, overrun_o);
      exp_led = led_expect(settings_pkg::LED_SRC_RESET, 8'h00, 1'b0, 1'b0);
      if (leds_o !== exp_led)
         report_mismatch("leds_o", exp_led, leds_o);
      idle(10);
      if (out_words.size() != 0)
         report_error("words appeared on the stream before run was set");
      finish_test();

      start_test("sample_path");
      start_stream($urandom_range(1, 8), $urandom_range(2, 4));
      idle(4 * (m_spp << m_shift) + 12);
      stop_stream();
      check_packets(3, 1'b1);
      finish_test();

      start_test("packet_timing");
      start_stream($urandom_range(1, 8), $urandom_range(2, 4));
      idle(4 * (m_spp << m_shift) + 12);
      stop_stream();
      check_packets(3, 1'b1);
      finish_test();

      // Stalled output fills the FIFO until packets are dropped
      start_test("overrun");
      ready_mode = 0;
      start_stream($urandom_range(4, 8), 2);
      n = 0;
      while (!overrun_o && n < 600) begin
         idle(1);
         n++;
      end
      if (!overrun_o)
         report_error("overrun_o did not rise with the output stalled");
      idle(40);
      ready_mode = 1;
      idle(m_spp * 4 * 6);
      stop_stream();
      check_packets(1, 1'b0);
      if (overrun_o !== 1'b1)
         report_mismatch("overrun_o while stopped", 1'b1, overrun_o);
      exp_led = led_expect(m_led_src, m_led_sw, m_run, 1'b1);
      if (leds_o !== exp_led)
         report_mismatch("leds_o with overrun set", exp_led, leds_o);
      write_reg(settings_pkg::SR_RUN, 32'd1);
      idle(2);
      if (overrun_o !== 1'b0)
         report_mismatch("overrun_o after restart", 1'b0, overrun_o);
      stop_stream();
      out_words.delete();
      finish_test();

      // Light traffic keeps overrun low here
      start_test("led_mux");
      ready_mode = 2;
      repeat (20) begin
         case ($urandom_range(0, 2))
            0:       write_reg(settings_pkg::SR_LED_SW, $urandom);
            1:       write_reg(settings_pkg::SR_LED_SRC, $urandom);
            default: write_reg(settings_pkg::SR_RUN, $urandom_range(0, 1));
         endcase
         idle(1);
         exp_led = led_expect(m_led_src, m_led_sw, m_run, 1'b0);
         if (leds_o !== exp_led)
            report_mismatch("leds_o", exp_led, leds_o);
      end
      stop_stream();
      out_words.delete();
      finish_test();

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
      if (tests_failed == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

//--- project.f
+incdir+bench
source/settings_pkg.sv
source/stream_pkg.sv
source/sample_if.sv
source/control_regs.sv
source/rx_frontend.sv
source/decim_stage.sv
source/vita_framer.sv
source/rx_core.sv
bench/tb_rx_core.sv

//--- source/control_regs.sv
// Control registers and radio time

module control_regs (
   input  logic                                dsp_clk,
   input  logic                                reset_i,
   input  logic                                set_stb_i,
   input  logic [settings_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [settings_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic                                overrun_i,
   output settings_pkg::rx_config_t            cfg_o,
   output logic [63:0]                         vita_time_o,
   output logic [7:0]                          leds_o
);

   settings_pkg::rx_config_t    cfg_q;
   settings_pkg::setting_addr_e set_addr;
   logic [31:0]                 time_hi_q;
   logic [63:0]                 time_q;
   logic [7:0]                  led_sw_q;
   logic [7:0]                  led_src_q;
   logic [7:0]                  led_hw;

   // Keep the shift inside the range the framer can handle
   function automatic logic [3:0] clamp_shift(input logic [31:0] data);
      if (data < stream_pkg::MIN_DECIM_SHIFT)
         return stream_pkg::MIN_DECIM_SHIFT;
      else if (data > stream_pkg::MAX_DECIM_SHIFT)
         return stream_pkg::MAX_DECIM_SHIFT;
      else
         return data[3:0];
   endfunction

   function automatic logic [4:0] clamp_spp(input logic [31:0] data);
      if (data == '0)
         return 5'd1;
      else if (data > stream_pkg::MAX_SPP)
         return stream_pkg::MAX_SPP;
      else
         return data[4:0];
   endfunction

   assign set_addr = settings_pkg::setting_addr_e'(set_addr_i);

   //////////////////////////////////////////////////////////////////////
   // Settings decode

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         cfg_q     <= settings_pkg::RX_CONFIG_RESET;
         time_hi_q <= '0;
         led_sw_q  <= '0;
         led_src_q <= settings_pkg::LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_addr)
            settings_pkg::SR_RUN:         cfg_q.run         <= set_data_i[0];
            settings_pkg::SR_LED_SW:      led_sw_q          <= set_data_i[7:0];
            settings_pkg::SR_LED_SRC:     led_src_q         <= set_data_i[7:0];
            settings_pkg::SR_TIME_HI:     time_hi_q         <= set_data_i;
            settings_pkg::SR_DC_OFFSET_I: cfg_q.dc_offset_i <= set_data_i[15:0];
            settings_pkg::SR_DC_OFFSET_Q: cfg_q.dc_offset_q <= set_data_i[15:0];
            settings_pkg::SR_IQ_SWAP:     cfg_q.iq_swap     <= set_data_i[0];
            settings_pkg::SR_SPP:         cfg_q.spp         <= clamp_spp(set_data_i);
            settings_pkg::SR_DECIM_SHIFT: cfg_q.decim_shift <= clamp_shift(set_data_i);
            default: ;
         endcase
      end
   end

   // Radio time, loaded as a whole by the low word write
   always_ff @(posedge dsp_clk) begin
      if (reset_i)
         time_q <= '0;
      else if (set_stb_i && (set_addr == settings_pkg::SR_TIME_LO))
         time_q <= {time_hi_q, set_data_i};
      else
         time_q <= time_q + 64'd1;
   end

   //////////////////////////////////////////////////////////////////////
   // LED source mux

   assign led_hw = {4'b0000, cfg_q.run, overrun_i, 2'b00};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   assign cfg_o       = cfg_q;
   assign vita_time_o = time_q;

endmodule

//--- source/decim_stage.sv
// Power-of-two decimator

module decim_stage (
   input  logic                     dsp_clk,
   input  logic                     reset_i,
   input  settings_pkg::rx_config_t cfg_i,
   sample_if.sink                   in,
   sample_if.source                 out
);

   logic signed [stream_pkg::DECIM_ACC_W-1:0] acc_i_q;
   logic signed [stream_pkg::DECIM_ACC_W-1:0] acc_q_q;
   logic signed [stream_pkg::DECIM_ACC_W-1:0] sum_i;
   logic signed [stream_pkg::DECIM_ACC_W-1:0] sum_q;
   logic signed [stream_pkg::DECIM_ACC_W-1:0] scaled_i;
   logic signed [stream_pkg::DECIM_ACC_W-1:0] scaled_q;
   logic [stream_pkg::MAX_DECIM_SHIFT-1:0]    grp_cnt_q;
   logic [stream_pkg::MAX_DECIM_SHIFT:0]      grp_len;
   logic                                      grp_ovf_q;
   logic                                      grp_done;

   always_comb begin
      sum_i    = acc_i_q + in.i;
      sum_q    = acc_q_q + in.q;
      // Arithmetic shift, rounds toward minus infinity
      scaled_i = sum_i >>> cfg_i.decim_shift;
      scaled_q = sum_q >>> cfg_i.decim_shift;
      grp_len  = {{stream_pkg::MAX_DECIM_SHIFT{1'b0}}, 1'b1} << cfg_i.decim_shift;
      grp_done = in.valid && ({1'b0, grp_cnt_q} == grp_len - 1'b1);
   end

   //////////////////////////////////////////////////////////////////////
   // Group accumulation

   always_ff @(posedge dsp_clk) begin
      if (reset_i || !cfg_i.run) begin
         acc_i_q   <= '0;
         acc_q_q   <= '0;
         grp_cnt_q <= '0;
         grp_ovf_q <= 1'b0;
         out.valid <= 1'b0;
      end else begin
         out.valid <= grp_done;
         if (grp_done) begin
            acc_i_q   <= '0;
            acc_q_q   <= '0;
            grp_cnt_q <= '0;
            grp_ovf_q <= 1'b0;
         end else if (in.valid) begin
            acc_i_q   <= sum_i;
            acc_q_q   <= sum_q;
            grp_cnt_q <= grp_cnt_q + 1'b1;
            grp_ovf_q <= grp_ovf_q | in.ovf;
         end
      end
   end

   // Decimated output sample
   always_ff @(posedge dsp_clk) begin
      if (grp_done) begin
         out.i   <= scaled_i[stream_pkg::SAMPLE_W-1:0];
         out.q   <= scaled_q[stream_pkg::SAMPLE_W-1:0];
         out.ovf <= grp_ovf_q | in.ovf;
      end
   end

endmodule

//--- source/rx_core.sv
// Receive channel top level

module rx_core (
   input  logic                                dsp_clk,
   input  logic                                reset_i,
   // Settings bus
   input  logic                                set_stb_i,
   input  logic [settings_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [settings_pkg::SET_DATA_W-1:0] set_data_i,
   // ADCs
   input  logic [stream_pkg::ADC_W-1:0]        adc_a_i,
   input  logic [stream_pkg::ADC_W-1:0]        adc_b_i,
   input  logic                                adc_ovf_a_i,
   input  logic                                adc_ovf_b_i,
   // Packet stream, src_rdy/dst_rdy style
   output logic [stream_pkg::FRAME_W-1:0]      rx_data_o,
   output logic                                rx_valid_o,
   input  logic                                rx_ready_i,
   output logic                                overrun_o,
   output logic [7:0]                          leds_o
);

   settings_pkg::rx_config_t cfg;
   logic [63:0]              vita_time;

   sample_if fe_if ();
   sample_if dec_if ();

   control_regs i_regs (
      .dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .overrun_i   (overrun_o),
      .cfg_o       (cfg),
      .vita_time_o (vita_time),
      .leds_o      (leds_o)
   );

   rx_frontend i_frontend (
      .dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .cfg_i       (cfg),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .adc_ovf_a_i (adc_ovf_a_i),
      .adc_ovf_b_i (adc_ovf_b_i),
      .out         (fe_if.source)
   );

   decim_stage i_decim (
      .dsp_clk (dsp_clk),
      .reset_i (reset_i),
      .cfg_i   (cfg),
      .in      (fe_if.sink),
      .out     (dec_if.source)
   );

   vita_framer i_framer (
      .dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .cfg_i       (cfg),
      .vita_time_i (vita_time),
      .in          (dec_if.sink),
      .data_o      (rx_data_o),
      .valid_o     (rx_valid_o),
      .ready_i     (rx_ready_i),
      .overrun_o   (overrun_o)
   );

endmodule

//--- source/rx_frontend.sv
// Receive front end

module rx_frontend (
   input  logic                           dsp_clk,
   input  logic                           reset_i,
   input  settings_pkg::rx_config_t       cfg_i,
   input  logic [stream_pkg::ADC_W-1:0]   adc_a_i,
   input  logic [stream_pkg::ADC_W-1:0]   adc_b_i,
   input  logic                           adc_ovf_a_i,
   input  logic                           adc_ovf_b_i,
   sample_if.source                       out
);

   logic [stream_pkg::ADC_W-1:0]          adc_i;
   logic [stream_pkg::ADC_W-1:0]          adc_q;

   // Scale the ADC word up to full width, subtract the offset, saturate
   function automatic logic signed [stream_pkg::SAMPLE_W-1:0] remove_dc(
      input logic [stream_pkg::ADC_W-1:0]          adc,
      input logic signed [stream_pkg::SAMPLE_W-1:0] offset
   );
      logic signed [stream_pkg::SAMPLE_W:0] diff;
      diff = $signed({adc[stream_pkg::ADC_W-1], adc, 2'b00}) - offset;
      if (diff[stream_pkg::SAMPLE_W] != diff[stream_pkg::SAMPLE_W-1])
         return diff[stream_pkg::SAMPLE_W] ?
            {1'b1, {(stream_pkg::SAMPLE_W-1){1'b0}}} :
            {1'b0, {(stream_pkg::SAMPLE_W-1){1'b1}}};
      else
         return diff[stream_pkg::SAMPLE_W-1:0];
   endfunction

   // I from ADC A unless swapped
   assign adc_i = cfg_i.iq_swap ? adc_b_i : adc_a_i;
   assign adc_q = cfg_i.iq_swap ? adc_a_i : adc_b_i;

   always_ff @(posedge dsp_clk) begin
      if (reset_i)
         out.valid <= 1'b0;
      else
         out.valid <= cfg_i.run;
   end

   // Sample registers run freely
   always_ff @(posedge dsp_clk) begin
      out.i   <= remove_dc(adc_i, cfg_i.dc_offset_i);
      out.q   <= remove_dc(adc_q, cfg_i.dc_offset_q);
      out.ovf <= adc_ovf_a_i | adc_ovf_b_i;
   end

endmodule

//--- source/sample_if.sv
// I/Q sample strobe interface

interface sample_if;

   logic signed [stream_pkg::SAMPLE_W-1:0] i;
   logic signed [stream_pkg::SAMPLE_W-1:0] q;
   // One-cycle strobe, no back-pressure
   logic                                   valid;
   logic                                   ovf;

   modport source (
      output i,
      output q,
      output valid,
      output ovf
   );

   modport sink (
      input i,
      input q,
      input valid,
      input ovf
   );

endinterface

//--- source/settings_pkg.sv
// Settings bus definitions

package settings_pkg;

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   // Register map of the receive channel
   typedef enum logic [SET_ADDR_W-1:0] {
      SR_RUN         = 8'd0,
      SR_LED_SW      = 8'd3,
      SR_LED_SRC     = 8'd6,
      SR_TIME_HI     = 8'd10,
      SR_TIME_LO     = 8'd11,
      SR_DC_OFFSET_I = 8'd24,
      SR_DC_OFFSET_Q = 8'd25,
      SR_IQ_SWAP     = 8'd26,
      SR_SPP         = 8'd32,
      SR_DECIM_SHIFT = 8'd48
   } setting_addr_e;

   // 1 = LED driven by hardware, 0 = by software
   localparam logic [7:0] LED_SRC_RESET = 8'h1E;

   typedef struct packed {
      logic               run;
      logic signed [15:0] dc_offset_i;
      logic signed [15:0] dc_offset_q;
      logic               iq_swap;
      logic [3:0]         decim_shift;
      logic [4:0]         spp;
   } rx_config_t;

   localparam rx_config_t RX_CONFIG_RESET = '{
      run:         1'b0,
      dc_offset_i: 16'sd0,
      dc_offset_q: 16'sd0,
      iq_swap:     1'b0,
      decim_shift: 4'd2,
      spp:         5'd16
   };

endpackage

//--- source/stream_pkg.sv
// Sample and stream definitions

package stream_pkg;

   //////////////////////////////////////////////////////////////////////
   // Sample widths

   localparam int ADC_W    = 14;
   localparam int SAMPLE_W = 16;

   // Decimation range, shift of the group length
   localparam logic [3:0] MIN_DECIM_SHIFT = 4'd2;
   localparam logic [3:0] MAX_DECIM_SHIFT = 4'd8;
   localparam int DECIM_ACC_W = SAMPLE_W + MAX_DECIM_SHIFT;

   //////////////////////////////////////////////////////////////////////
   // 36-bit stream words

   localparam int FRAME_W  = 36;
   localparam int FLAG_SOF = 32;
   localparam int FLAG_EOF = 33;
   localparam int FLAG_OVF = 34;

   // Framer limits
   localparam int FIFO_DEPTH = 32;
   localparam int FIFO_AW    = 5;
   localparam logic [4:0] MAX_SPP = 5'd16;

   typedef enum logic [1:0] {
      FR_IDLE,
      FR_HDR_LO,
      FR_FIRST,
      FR_BODY
   } framer_state_e;

endpackage

//--- source/vita_framer.sv
// Timestamped packet framer

module vita_framer (
   input  logic                           dsp_clk,
   input  logic                           reset_i,
   input  settings_pkg::rx_config_t       cfg_i,
   input  logic [63:0]                    vita_time_i,
   sample_if.sink                         in,
   output logic [stream_pkg::FRAME_W-1:0] data_o,
   output logic                           valid_o,
   input  logic                           ready_i,
   output logic                           overrun_o
);

   stream_pkg::framer_state_e      state_q;
   logic [4:0]                     count_q;
   logic                           skip_q;
   logic                           run_q;
   logic [31:0]                    time_lo_q;
   logic [31:0]                    first_iq_q;
   logic                           first_ovf_q;
   logic [stream_pkg::FRAME_W-1:0] fifo_mem [stream_pkg::FIFO_DEPTH];
   logic [stream_pkg::FIFO_AW-1:0] wr_ptr_q;
   logic [stream_pkg::FIFO_AW-1:0] rd_ptr_q;
   logic [stream_pkg::FIFO_AW:0]   fill_q;
   logic [stream_pkg::FRAME_W-1:0] wr_data;
   logic                           wr_en;
   logic                           rd_en;
   logic                           pkt_start;
   logic                           room;
   logic                           last_body;

   function automatic logic [stream_pkg::FRAME_W-1:0] make_word(
      input logic [31:0] payload,
      input logic        sof,
      input logic        eof,
      input logic        ovf
   );
      logic [stream_pkg::FRAME_W-1:0] w;
      w                      = '0;
      w[31:0]                = payload;
      w[stream_pkg::FLAG_SOF] = sof;
      w[stream_pkg::FLAG_EOF] = eof;
      w[stream_pkg::FLAG_OVF] = ovf;
      return w;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Write port

   always_comb begin
      pkt_start = (state_q == stream_pkg::FR_IDLE) && in.valid && cfg_i.run;
      // Whole packet plus both header words must fit
      room      = (fill_q + cfg_i.spp + 2) <= stream_pkg::FIFO_DEPTH;
      last_body = (count_q == cfg_i.spp - 5'd1);
      wr_en     = 1'b0;
      wr_data   = make_word({in.i, in.q}, 1'b0, last_body, in.ovf);
      case (state_q)
         stream_pkg::FR_IDLE: begin
            wr_en   = pkt_start && room;
            wr_data = make_word(vita_time_i[63:32], 1'b1, 1'b0, 1'b0);
         end
         stream_pkg::FR_HDR_LO: begin
            wr_en   = cfg_i.run;
            wr_data = make_word(time_lo_q, 1'b0, 1'b0, 1'b0);
         end
         stream_pkg::FR_FIRST: begin
            wr_en   = cfg_i.run;
            wr_data = make_word(first_iq_q, 1'b0, cfg_i.spp == 5'd1, first_ovf_q);
         end
         default: wr_en = cfg_i.run && in.valid && !skip_q;
      endcase
   end

   // Packet FSM
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         state_q   <= stream_pkg::FR_IDLE;
         count_q   <= '0;
         skip_q    <= 1'b0;
         run_q     <= 1'b0;
         overrun_o <= 1'b0;
      end else begin
         run_q <= cfg_i.run;
         if (cfg_i.run && !run_q)
            overrun_o <= 1'b0;
         if (!cfg_i.run) begin
            state_q <= stream_pkg::FR_IDLE;
            skip_q  <= 1'b0;
         end else begin
            case (state_q)
               stream_pkg::FR_IDLE: begin
                  if (pkt_start) begin
                     count_q <= 5'd1;
                     skip_q  <= !room;
                     if (room)
                        state_q <= stream_pkg::FR_HDR_LO;
                     else begin
                        // Drop this packet, its samples are counted off in FR_BODY
                        overrun_o <= 1'b1;
                        if (cfg_i.spp != 5'd1)
                           state_q <= stream_pkg::FR_BODY;
                     end
                  end
               end
               stream_pkg::FR_HDR_LO: state_q <= stream_pkg::FR_FIRST;
               stream_pkg::FR_FIRST: begin
                  state_q <= (cfg_i.spp == 5'd1) ? stream_pkg::FR_IDLE : stream_pkg::FR_BODY;
               end
               default: begin
                  if (in.valid) begin
                     count_q <= count_q + 5'd1;
                     if (last_body)
                        state_q <= stream_pkg::FR_IDLE;
                  end
               end
            endcase
         end
      end
   end

   // Low time word and first sample wait for their slots
   always_ff @(posedge dsp_clk) begin
      if (pkt_start) begin
         time_lo_q   <= vita_time_i[31:0];
         first_iq_q  <= {in.i, in.q};
         first_ovf_q <= in.ovf;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Output FIFO

   assign rd_en   = valid_o && ready_i;
   assign valid_o = (fill_q != '0);
   assign data_o  = fifo_mem[rd_ptr_q];

   always_ff @(posedge dsp_clk) begin
      if (wr_en)
         fifo_mem[wr_ptr_q] <= wr_data;
   end

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         fill_q   <= '0;
      end else begin
         if (wr_en)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd_en)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   fill_q <= fill_q + 1'b1;
            2'b01:   fill_q <= fill_q - 1'b1;
            default: fill_q <= fill_q;
         endcase
      end
   end

endmodule
